//--- hw/cart_config.svh
`ifndef CART_CONFIG_SVH
`define CART_CONFIG_SVH

////////////////////////////////////////
// bus widths
////////////////////////////////////////

`define SNES_ADDR_W 24  // console byte address
`define ROM_ADDR_W  23  // psram word address, 16-bit words

// length of every console pin sampling shift register
`define SYNC_DEPTH 8

////////////////////////////////////////
// timing, in CLK2 cycles
////////////////////////////////////////

// reload value of the psram access delay
`define ROM_CYCLE_LEN 8

// console clock held low this long means the console is off, about 1 ms
`define SNES_DEAD_TIMEOUT 96000
`define DEAD_CNT_W        18  // must hold SNES_DEAD_TIMEOUT plus a few

`endif

//--- hw/cart_main.sv
`timescale 1ns/1ps
`include "cart_config.svh"

module cart_main (
  input  logic                    CLK2,
  input  logic                    rst_n,
  input  logic [`SNES_ADDR_W-1:0] snes_addr,
  input  logic                    snes_rd_n,
  input  logic                    snes_wr_n,
  input  logic                    snes_romsel_n,
  input  logic                    snes_cpu_clk,
  input  cart_pkg::mcu_req_t      mcu,
  input  logic [15:0]             rom_rdata,
  output logic [7:0]              snes_rdata,
  output logic                    mcu_rdy,
  output logic [7:0]              mcu_rdata,
  output logic                    snes_dead,
  output cart_pkg::rom_out_t      rom,
  output cart_pkg::rom_wr_t       rom_wr
);
  import cart_pkg::*;

  snes_bus_t               bus;
  snes_evt_t               evt;
  logic                    revive;
  arb_state_e              state;
  logic [`SNES_ADDR_W-1:0] mcu_addr;
  logic [7:0]              mcu_wdata;
  logic [7:0]              rom_byte;

  ////////////////////////////////////////
  // console side
  ////////////////////////////////////////

  snes_bus_sync i_bus_sync (
    .CLK2          (CLK2),
    .rst_n         (rst_n),
    .snes_addr     (snes_addr),
    .snes_rd_n     (snes_rd_n),
    .snes_wr_n     (snes_wr_n),
    .snes_romsel_n (snes_romsel_n),
    .snes_cpu_clk  (snes_cpu_clk),
    .bus           (bus),
    .evt           (evt)
  );

  snes_alive_timer i_alive_timer (
    .CLK2    (CLK2),
    .rst_n   (rst_n),
    .cpu_clk (evt.cpu_clk),
    .dead    (snes_dead),
    .revive  (revive)
  );

  ////////////////////////////////////////
  // rom access
  ////////////////////////////////////////

  rom_arbiter i_rom_arbiter (
    .CLK2      (CLK2),
    .rst_n     (rst_n),
    .mcu       (mcu),
    .evt       (evt),
    .romsel_n  (bus.romsel_n),
    .dead      (snes_dead),
    .revive    (revive),
    .rom_byte  (rom_byte),
    .rdy       (mcu_rdy),
    .mcu_rdata (mcu_rdata),
    .state     (state),
    .mcu_addr  (mcu_addr),
    .mcu_wdata (mcu_wdata)
  );

  rom_port i_rom_port (
    .state     (state),
    .mcu_addr  (mcu_addr),
    .mcu_wdata (mcu_wdata),
    .bus       (bus),
    .rom_rdata (rom_rdata),
    .rom       (rom),
    .wr        (rom_wr),
    .rom_byte  (rom_byte)
  );

  assign snes_rdata = rom_byte;  // console sees the selected lane

endmodule

//--- hw/cart_pkg.sv
`include "cart_config.svh"

package cart_pkg;

  // arbiter states, one access in flight at a time
  typedef enum logic [2:0] {
    ST_IDLE        = 3'd0,
    ST_MCU_RD_ADDR = 3'd1,
    ST_MCU_RD_END  = 3'd2,
    ST_MCU_WR_ADDR = 3'd3,
    ST_MCU_WR_END  = 3'd4
  } arb_state_e;

  ////////////////////////////////////////
  // console side
  ////////////////////////////////////////

  typedef struct packed {
    logic [`SNES_ADDR_W-1:0] addr;
    logic                    rd_n;
    logic                    wr_n;
    logic                    romsel_n;
  } snes_bus_t;

  // one-cycle strobes, except cpu_clk which is a level
  typedef struct packed {
    logic pulse_end;    // bus access over
    logic cycle_start;  // cpu clock rose
    logic rd_start;     // read fell
    logic cpu_clk;
  } snes_evt_t;

  ////////////////////////////////////////
  // mcu and rom side
  ////////////////////////////////////////

  typedef struct packed {
    logic                    rrq;
    logic                    wrq;
    logic [`SNES_ADDR_W-1:0] addr;
    logic [7:0]              wdata;
  } mcu_req_t;

  typedef struct packed {
    logic [`ROM_ADDR_W-1:0] addr;
    logic                   we_n;
    logic                   bhe_n;
    logic                   ble_n;
  } rom_out_t;

  typedef struct packed {
    logic [7:0] data;
    logic       drive;  // fpga owns the rom data bus
  } rom_wr_t;

endpackage

//--- hw/rom_arbiter.sv
`timescale 1ns/1ps
`include "cart_config.svh"

module rom_arbiter (
  input  logic                    CLK2,
  input  logic                    rst_n,
  input  cart_pkg::mcu_req_t      mcu,
  input  cart_pkg::snes_evt_t     evt,
  input  logic                    romsel_n,
  input  logic                    dead,
  input  logic                    revive,
  input  logic [7:0]              rom_byte,
  output logic                    rdy,
  output logic [7:0]              mcu_rdata,
  output cart_pkg::arb_state_e    state,
  output logic [`SNES_ADDR_W-1:0] mcu_addr,
  output logic [7:0]              mcu_wdata
);
  import cart_pkg::*;

  localparam int               DLY_W    = $clog2(`ROM_CYCLE_LEN + 1);
  localparam logic [DLY_W-1:0] DLY_LOAD = DLY_W'(`ROM_CYCLE_LEN);

  logic             rd_pend;
  logic             wr_pend;
  logic             free_strobe;  // cpu cycle that does not touch rom
  logic             free_slot;
  logic             acc_end;
  logic [DLY_W-1:0] dly_cnt;

  assign free_slot = evt.pulse_end | free_strobe | dead;
  assign acc_end   = (state == ST_MCU_RD_END) || (state == ST_MCU_WR_END);

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= evt.cycle_start & romsel_n;
    end
  end

  ////////////////////////////////////////
  // request handshake
  ////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      rdy     <= 1'b1;
    end else if (mcu.rrq) begin
      rd_pend <= 1'b1;
      rdy     <= 1'b0;
    end else if (mcu.wrq) begin
      wr_pend <= 1'b1;
      rdy     <= 1'b0;
    end else if (acc_end) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      rdy     <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (mcu.rrq | mcu.wrq) mcu_addr <= mcu.addr;
    if (mcu.wrq) mcu_wdata <= mcu.wdata;
    if (state == ST_MCU_RD_ADDR) mcu_rdata <= rom_byte;  // last sample wins
  end

  ////////////////////////////////////////
  // slot fsm
  ////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      state   <= ST_IDLE;
      dly_cnt <= '0;
    end else if (revive) begin
      state <= ST_IDLE;  // console is back, pending access restarts later
    end else begin
      case (state)
        ST_IDLE: begin
          if (free_slot && rd_pend) begin
            state   <= ST_MCU_RD_ADDR;
            dly_cnt <= DLY_LOAD;
          end else if (free_slot && wr_pend) begin
            state   <= ST_MCU_WR_ADDR;
            dly_cnt <= DLY_LOAD;
          end
        end
        ST_MCU_RD_ADDR, ST_MCU_WR_ADDR: begin
          dly_cnt <= dly_cnt - 1'b1;
          if (dly_cnt == '0) begin
            state <= (state == ST_MCU_RD_ADDR) ? ST_MCU_RD_END : ST_MCU_WR_END;
          end
        end
        default: state <= ST_IDLE;  // both END states last one cycle
      endcase
    end
  end

endmodule

//--- hw/rom_port.sv
`timescale 1ns/1ps
`include "cart_config.svh"

module rom_port (
  input  cart_pkg::arb_state_e    state,
  input  logic [`SNES_ADDR_W-1:0] mcu_addr,
  input  logic [7:0]              mcu_wdata,
  input  cart_pkg::snes_bus_t     bus,
  input  logic [15:0]             rom_rdata,
  output cart_pkg::rom_out_t      rom,
  output cart_pkg::rom_wr_t       wr,
  output logic [7:0]              rom_byte
);
  import cart_pkg::*;

  logic                    mcu_hit;  // mcu owns the rom address
  logic                    mcu_we;
  logic [`SNES_ADDR_W-1:0] byte_addr;

  assign mcu_hit = (state != ST_IDLE);
  assign mcu_we  = (state == ST_MCU_WR_ADDR);

  ////////////////////////////////////////
  // address and lanes
  ////////////////////////////////////////

  assign byte_addr = mcu_hit ? mcu_addr : bus.addr;

  always_comb begin
    rom.addr  = byte_addr[`ROM_ADDR_W:1];
    rom.we_n  = ~mcu_we;
    // odd byte lives in the low lane
    rom.bhe_n = byte_addr[0];
    rom.ble_n = ~byte_addr[0];
  end

  ////////////////////////////////////////
  // data paths
  ////////////////////////////////////////

  // write byte is put on both lanes, the enables pick one
  assign wr.data  = mcu_wdata;
  assign wr.drive = mcu_we;

  // shared by console reads and mcu reads
  assign rom_byte = byte_addr[0] ? rom_rdata[7:0] : rom_rdata[15:8];

endmodule

//--- hw/snes_alive_timer.sv
`timescale 1ns/1ps
`include "cart_config.svh"

module snes_alive_timer (
  input  logic CLK2,
  input  logic rst_n,
  input  logic cpu_clk,
  output logic dead,
  output logic revive
);

  localparam logic [`DEAD_CNT_W-1:0] TIMEOUT = `SNES_DEAD_TIMEOUT;

  logic [`DEAD_CNT_W-1:0] low_cnt;  // cycles since the cpu clock was last high

  // count the low phase; the count freezes once dead so it cannot wrap
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      low_cnt <= '0;
    end else if (cpu_clk) begin
      low_cnt <= '0;
    end else if (!dead) begin
      low_cnt <= low_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////
  // dead flag and revival
  ////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      dead   <= 1'b1;  // no console until its clock is seen
      revive <= 1'b0;
    end else begin
      revive <= 1'b0;
      if (cpu_clk) begin
        dead   <= 1'b0;
        revive <= dead;  // first high clock after a dead spell
      end else if (low_cnt > TIMEOUT) begin
        dead <= 1'b1;
      end
    end
  end

endmodule

//--- hw/snes_bus_sync.sv
`timescale 1ns/1ps
`include "cart_config.svh"

module snes_bus_sync (
  input  logic                    CLK2,
  input  logic                    rst_n,
  input  logic [`SNES_ADDR_W-1:0] snes_addr,
  input  logic                    snes_rd_n,
  input  logic                    snes_wr_n,
  input  logic                    snes_romsel_n,
  input  logic                    snes_cpu_clk,
  output cart_pkg::snes_bus_t     bus,
  output cart_pkg::snes_evt_t     evt
);

  localparam int DEPTH = `SYNC_DEPTH;
  localparam int OLD   = DEPTH - 6;  // lowest tap of the six-tap edge window

  logic [DEPTH-1:0] rd_sr;
  logic [DEPTH-1:0] wr_sr;
  logic [DEPTH-1:0] romsel_sr;
  logic [DEPTH-1:0] cpu_clk_sr;
  logic [DEPTH-1:0] pulse_sr;

  logic [`SNES_ADDR_W-1:0] addr_sr [DEPTH];

  // bus idle: no read or write strobe, clock in its low phase
  logic pulse_in;

  assign pulse_in = snes_rd_n & snes_wr_n & ~snes_cpu_clk;

  ////////////////////////////////////////
  // sampling
  ////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      rd_sr      <= '1;  // strobes idle high
      wr_sr      <= '1;
      romsel_sr  <= '1;
      pulse_sr   <= '1;
      cpu_clk_sr <= '0;
    end else begin
      rd_sr      <= {rd_sr[DEPTH-2:0], snes_rd_n};
      wr_sr      <= {wr_sr[DEPTH-2:0], snes_wr_n};
      romsel_sr  <= {romsel_sr[DEPTH-2:0], snes_romsel_n};
      pulse_sr   <= {pulse_sr[DEPTH-2:0], pulse_in};
      cpu_clk_sr <= {cpu_clk_sr[DEPTH-2:0], snes_cpu_clk};
    end
  end

  always_ff @(posedge CLK2) begin
    addr_sr[0] <= snes_addr;
    for (int i = 1; i < DEPTH; i++) begin
      addr_sr[i] <= addr_sr[i-1];
    end
  end

  ////////////////////////////////////////
  // filtered levels
  ////////////////////////////////////////

  // address and romsel settle late, so take them from deeper taps
  assign bus.addr     = addr_sr[5] & addr_sr[4];
  assign bus.romsel_n = romsel_sr[5] & romsel_sr[4];
  assign bus.rd_n     = rd_sr[2] & rd_sr[1];
  assign bus.wr_n     = wr_sr[2] & wr_sr[1];
  assign evt.cpu_clk  = cpu_clk_sr[2] & cpu_clk_sr[1];

  ////////////////////////////////////////
  // edge strobes
  ////////////////////////////////////////

  // oldest tap on the left; each pattern matches for exactly one cycle
  assign evt.pulse_end   = (pulse_sr[DEPTH-1:OLD] == 6'b000011);
  assign evt.cycle_start = (cpu_clk_sr[DEPTH-1:OLD] == 6'b000001);
  assign evt.rd_start    = (rd_sr[DEPTH-1:OLD] == 6'b111110);  // read went low

endmodule

//--- project.f
+incdir+hw
hw/cart_pkg.sv
hw/snes_bus_sync.sv
hw/snes_alive_timer.sv
hw/rom_arbiter.sv
hw/rom_port.sv
hw/cart_main.sv
tests/cart_asserts.sv
tests/tb_cart_main.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_cart_main \
  -f project.f -Mdir obj_dir -o sim_cart_main > build.log 2>&1 \
  || { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/sim_cart_main > sim.log 2>&1
grep -qx "test passed" sim.log && echo "simulation ok" \
  || { echo "simulation failure, see sim.log"; exit 1; }

//--- tests/cart_asserts.sv
`timescale 1ns/1ps

module cart_asserts (
  input logic                 CLK2,
  input logic                 rst_n,
  input cart_pkg::arb_state_e state,
  input logic                 rdy,
  input cart_pkg::rom_out_t   rom,
  input cart_pkg::rom_wr_t    wr
);
  import cart_pkg::*;

  logic in_end;

  assign in_end = (state == ST_MCU_RD_END) || (state == ST_MCU_WR_END);

  ////////////////////////////////////////
  // arbiter fsm
  ////////////////////////////////////////

  end_one_cycle: assert property (@(posedge CLK2) disable iff (!rst_n)
    in_end |=> (state == ST_IDLE))
    else $error("arbiter stayed in an END state");

  busy_not_ready: assert property (@(posedge CLK2) disable iff (!rst_n)
    (state != ST_IDLE) |-> !rdy)
    else $error("rdy high while the arbiter is busy");

  ////////////////////////////////////////
  // rom strobes
  ////////////////////////////////////////

  write_drives: assert property (@(posedge CLK2) disable iff (!rst_n)
    !rom.we_n |-> wr.drive)
    else $error("rom write without data drive");

  one_lane: assert property (@(posedge CLK2) disable iff (!rst_n)
    rom.bhe_n != rom.ble_n)
    else $error("byte enables not complementary");

endmodule

// arbiter and rom port signals meet in the top level
bind cart_main cart_asserts i_cart_asserts (
  .CLK2  (CLK2),
  .rst_n (rst_n),
  .state (state),
  .rdy   (mcu_rdy),
  .rom   (rom),
  .wr    (rom_wr)
);

//--- tests/tb_cart_main.sv
`timescale 1ns/1ps
`include "cart_config.svh"

module tb_cart_main;
  import cart_pkg::*;

  localparam int TIMEOUT     = `SNES_DEAD_TIMEOUT;
  localparam int ACC_LAT     = `ROM_CYCLE_LEN + 4;  // strobe to rdy while dead
  localparam int CYCLE_LIMIT = 3 * TIMEOUT + 2000;
  localparam int RDY_LIMIT   = 100;
  localparam int HALF_CPU    = 16;  // console clock phase in CLK2 cycles

  logic                    CLK2 = 1'b0;
  logic                    rst_n;
  logic [`SNES_ADDR_W-1:0] snes_addr;
  logic                    snes_rd_n;
  logic                    snes_wr_n;
  logic                    snes_romsel_n;
  logic                    snes_cpu_clk;
  mcu_req_t                mcu;
  logic [15:0]             rom_rdata;
  logic [7:0]              snes_rdata;
  logic [7:0]              mcu_rdata;
  logic                    mcu_rdy;
  logic                    snes_dead;
  rom_out_t                rom;
  rom_wr_t                 rom_wr;

  logic [15:0] rom_mem [256];
  logic [15:0] exp_mem [256];  // what the rom should hold
  logic [23:0] wr_addrs [$];
  logic [31:0] rng = 32'hd3e5_ed0e;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          rdy_wait;

  always #2 CLK2 = ~CLK2;

  cart_main i_cart_main (
    .CLK2          (CLK2),
    .rst_n         (rst_n),
    .snes_addr     (snes_addr),
    .snes_rd_n     (snes_rd_n),
    .snes_wr_n     (snes_wr_n),
    .snes_romsel_n (snes_romsel_n),
    .snes_cpu_clk  (snes_cpu_clk),
    .mcu           (mcu),
    .rom_rdata     (rom_rdata),
    .snes_rdata    (snes_rdata),
    .mcu_rdy       (mcu_rdy),
    .mcu_rdata     (mcu_rdata),
    .snes_dead     (snes_dead),
    .rom           (rom),
    .rom_wr        (rom_wr)
  );

  ////////////////////////////////////////
  // psram model of 256 words
  ////////////////////////////////////////

  assign rom_rdata = rom_mem[rom.addr[7:0]];

  // writes only happen in ST_MCU_WR_ADDR, never on a read sampling edge
  always @(posedge CLK2) begin
    if (!rom.we_n) begin
      if (!rom.bhe_n) rom_mem[rom.addr[7:0]][15:8] = rom_wr.data;
      if (!rom.ble_n) rom_mem[rom.addr[7:0]][7:0] = rom_wr.data;
    end
  end

  always @(posedge CLK2) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("run hit the cycle limit of %0d without a verdict", CYCLE_LIMIT);
      $display("test failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [15:0] fill_word(input int i);
    return {~i[7:0], i[7:0] ^ 8'h5a};
  endfunction

  // odd byte address is the low lane
  function automatic logic [7:0] exp_byte(input logic [23:0] a);
    return a[0] ? exp_mem[a[8:1]][7:0] : exp_mem[a[8:1]][15:8];
  endfunction

  task automatic store_expected(input logic [23:0] a, input logic [7:0] d);
    if (a[0]) exp_mem[a[8:1]][7:0] = d;
    else exp_mem[a[8:1]][15:8] = d;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // bus drivers entered 1 ns after an edge
  ////////////////////////////////////////

  task automatic mcu_access(input logic write, input logic [23:0] a, input logic [7:0] d);
    mcu.rrq   = ~write;
    mcu.wrq   = write;
    mcu.addr  = a;
    mcu.wdata = d;
    @(posedge CLK2);
    #1;
    mcu.rrq  = 1'b0;  // single cycle strobe
    mcu.wrq  = 1'b0;
    rdy_wait = 1;
    while (!mcu_rdy && rdy_wait < RDY_LIMIT) begin
      @(posedge CLK2);
      #1;
      rdy_wait++;
    end
    checks++;
    assert (mcu_rdy) else begin
      errors++;
      $display("mcu access to %h got no rdy within %0d cycles", a, RDY_LIMIT);
    end
  endtask

  // one cpu cycle with an idle low phase and a rom read in the high phase
  task automatic console_read(input logic [23:0] a);
    snes_addr     = a;
    snes_romsel_n = 1'b0;
    snes_rd_n     = 1'b1;
    snes_cpu_clk  = 1'b0;
    repeat (HALF_CPU) @(posedge CLK2);
    #1;
    snes_cpu_clk = 1'b1;
    snes_rd_n    = 1'b0;
    repeat (HALF_CPU - 1) @(posedge CLK2);
    #1;
    check_value("snes_rdata", snes_rdata, exp_byte(a));  // late in the read when settled
    @(posedge CLK2);
    #1;
  endtask

  task automatic console_idle();
    snes_romsel_n = 1'b1;
    snes_rd_n     = 1'b1;
    snes_cpu_clk  = 1'b0;
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic reset_values();
    check_value("mcu_rdy", mcu_rdy, 1);
    check_value("rom.we_n", rom.we_n, 1);
    check_value("rom_wr.drive", rom_wr.drive, 0);
    check_value("snes_dead", snes_dead, 1);
  endtask

  task automatic writes_while_dead();
    logic [23:0] a;
    logic [7:0]  d;
    for (int i = 0; i < 6; i++) begin
      rng = xorshift(rng);
      a = {16'd0, rng[6:0], i[0]};  // words below 0x80 with alternating lanes
      d = rng[15:8];
      mcu_access(1'b1, a, d);
      check_value("mcu_rdy latency", rdy_wait, ACC_LAT);
      store_expected(a, d);
      check_value("rom word", rom_mem[a[8:1]], exp_mem[a[8:1]]);
      wr_addrs.push_back(a);
    end
  endtask

  task automatic reads_while_dead();
    foreach (wr_addrs[i]) begin
      mcu_access(1'b0, wr_addrs[i], 8'h00);
      check_value("mcu_rdata", mcu_rdata, exp_byte(wr_addrs[i]));
    end
  endtask

  task automatic alive_reads_and_timeout();
    logic [23:0] a;
    int          n;
    rng = xorshift(rng);
    a = {15'd0, 1'b1, rng[6:0], 1'b0};  // preloaded word that is never written
    console_read(a);
    check_value("snes_dead", snes_dead, 0);
    for (int i = 0; i < 4; i++) console_read({a[23:1], i[0]});
    console_idle();
    n = 0;
    while (!snes_dead) begin
      @(posedge CLK2);
      #1;
      n++;
    end
    checks++;
    assert (n > TIMEOUT && n < TIMEOUT + 16) else begin
      errors++;
      $display("snes_dead rose after %0d low clock cycles, limit is %0d", n, TIMEOUT);
    end
  endtask

  task automatic shared_bus_access();
    logic [23:0] con_a;
    logic [23:0] wa;
    logic [7:0]  wd;
    rng = xorshift(rng);
    con_a = {15'd0, 1'b1, rng[6:0], rng[7]};
    wa    = {16'd0, rng[14:8], rng[15]};
    wd    = rng[23:16];
    fork
      for (int i = 0; i < 8; i++) console_read(con_a);
      begin
        repeat (2 * HALF_CPU) @(posedge CLK2);  // first cycle revives the console
        #1;
        mcu_access(1'b0, wr_addrs[0], 8'h00);
        check_value("mcu_rdata", mcu_rdata, exp_byte(wr_addrs[0]));
        mcu_access(1'b1, wa, wd);
        store_expected(wa, wd);
        check_value("rom word", rom_mem[wa[8:1]], exp_mem[wa[8:1]]);
      end
    join
    console_idle();
  endtask

  initial begin
    for (int i = 0; i < 256; i++) begin
      rom_mem[i] = fill_word(i);
      exp_mem[i] = fill_word(i);
    end
    rst_n         = 1'b0;
    snes_addr     = '0;
    snes_rd_n     = 1'b1;
    snes_wr_n     = 1'b1;
    snes_romsel_n = 1'b1;
    snes_cpu_clk  = 1'b0;
    mcu           = '0;
    repeat (3) @(posedge CLK2);
    #1;
    rst_n = 1'b1;
    reset_values();
    writes_while_dead();
    reads_while_dead();
    alive_reads_and_timeout();
    shared_bus_access();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
